/* Makefile */
VERILATOR ?= verilator
TOP       ?= reorderBufferTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/reorderBuffer.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module reorderBuffer (
    input  logic                clk,
    input  logic                rstN,
    input  robPkg::robDispatchT dispatch,
    output robPkg::robPtrT      allocPtr,
    output logic                full,
    input  robPkg::robWbT       wb,
    input  robPkg::robRedirectT redirect,
    output robPkg::robCommitT   commit,
    output robPkg::robWalkT     walk
);

    robPkg::robPtrT    head;
    robPkg::robPtrT    tail;
    robPkg::robCountT  validCount;
    robPkg::robCountT  freeCount;
    robPkg::slotCountT dispCount;
    robPkg::slotCountT acceptNum;
    logic              dispAccept;

    logic [`DISPATCH_W-1:0]             wrEn;
    robPkg::robIdxT [`DISPATCH_W-1:0]   wrIdx;
    robPkg::robIdxT [`COMMIT_W-1:0]     commitRdIdx;
    robPkg::robIdxT [`COMMIT_W-1:0]     walkRdIdx;
    robPkg::robIdxT [`COMMIT_W-1:0]     ramRdIdx;
    robPkg::robEntryT [`COMMIT_W-1:0]   ramRdData;

    logic [`COMMIT_W-1:0] readyMask;
    logic [`COMMIT_W-1:0] retireMask;
    logic [`COMMIT_W-1:0] retireWe;
    robPkg::slotCountT    retireNum;
    logic                 walkSel;
    robPkg::robPtrT       tailRewind;
    logic                 rewindEn;

    logic [`COMMIT_W-1:0]             commitEnQ;
    robPkg::slotCountT                commitNumQ;
    robPkg::slotCountT                commitWeNumQ;
    robPkg::robEntryT [`COMMIT_W-1:0] commitEntryQ;

    // occupancy straight from the wrap-tagged pointers
    assign validCount = robPkg::robCountT'(tail - head);
    assign freeCount  = robPkg::robCountT'(`ROB_SIZE) - validCount;

    assign dispCount  = robPkg::slotCountT'($countones(dispatch.en));
    assign full       = freeCount < robPkg::robCountT'(dispCount);
    assign dispAccept = (|dispatch.en) && !full && !walk.active && !redirect.en;
    assign acceptNum  = dispAccept ? dispCount : '0;
    assign allocPtr   = tail;

    always_comb begin
        for (int i = 0; i < `DISPATCH_W; i++) begin
            wrEn[i]  = dispAccept & dispatch.en[i];
            wrIdx[i] = robPkg::robIdxT'(tail.idx + robPkg::robIdxT'(i));
        end
    end

    // walk owns the read ports from the redirect cycle on
    assign walkSel = redirect.en || walk.active;

    always_comb begin
        for (int i = 0; i < `COMMIT_W; i++) begin
            commitRdIdx[i] = robPkg::robIdxT'(head.idx + robPkg::robIdxT'(i));
            ramRdIdx[i]    = walkSel ? walkRdIdx[i] : commitRdIdx[i];
        end
    end

    assign retireMask = walkSel ? '0 : readyMask;
    assign retireNum  = robPkg::slotCountT'($countones(retireMask));

    always_comb begin
        for (int i = 0; i < `COMMIT_W; i++) begin
            retireWe[i] = retireMask[i] & ramRdData[i].we;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head         <= '0;
            tail         <= '0;
            commitEnQ    <= '0;
            commitNumQ   <= '0;
            commitWeNumQ <= '0;
        end else begin
            head <= robPkg::robPtrT'(head + robPkg::robCountT'(retireNum));
            if (rewindEn) begin
                tail <= tailRewind; // drop the squashed entries
            end else begin
                tail <= robPkg::robPtrT'(tail + robPkg::robCountT'(acceptNum));
            end
            commitEnQ    <= retireMask;
            commitNumQ   <= retireNum;
            commitWeNumQ <= robPkg::slotCountT'($countones(retireWe));
        end
    end

    always_ff @(posedge clk) begin
        commitEntryQ <= ramRdData;
    end

    always_comb begin
        commit.en    = commitEnQ;
        commit.num   = commitNumQ;
        commit.weNum = commitWeNumQ;
        commit.entry = commitEntryQ;
    end

    robEntryRam #(
        .DEPTH   (`ROB_SIZE),
        .RD_PORTS(`COMMIT_W),
        .WR_PORTS(`DISPATCH_W)
    ) i_entryRam (
        .clk   (clk),
        .wrEn  (wrEn),
        .wrIdx (wrIdx),
        .wrData(dispatch.entry),
        .rdIdx (ramRdIdx),
        .rdData(ramRdData)
    );

    robCompletionTracker i_completion (
        .clk      (clk),
        .rstN     (rstN),
        .allocEn  (wrEn),
        .allocIdx (wrIdx),
        .wb       (wb),
        .head     (head.idx),
        .valid    (validCount),
        .readyMask(readyMask)
    );

    robWalkUnit i_walk (
        .clk       (clk),
        .rstN      (rstN),
        .redirect  (redirect),
        .tail      (tail),
        .rdIdx     (walkRdIdx),
        .rdData    (ramRdData),
        .walk      (walk),
        .tailRewind(tailRewind),
        .rewindEn  (rewindEn)
    );

endmodule

/* hdl/robCompletionTracker.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module robCompletionTracker (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [`DISPATCH_W-1:0]             allocEn,
    input  robPkg::robIdxT [`DISPATCH_W-1:0]   allocIdx,
    input  robPkg::robWbT                      wb,
    input  robPkg::robIdxT                     head,
    input  robPkg::robCountT                   valid,
    output logic [`COMMIT_W-1:0]               readyMask
);

    logic [`ROB_SIZE-1:0] done;
    logic [`COMMIT_W-1:0] rawReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            done <= '0;
        end else begin
            for (int i = 0; i < `DISPATCH_W; i++) begin
                if (allocEn[i]) begin
                    done[allocIdx[i]] <= 1'b0; // fresh entry
                end
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb.port[p].en) begin
                    done[wb.port[p].ptr.idx] <= 1'b1;
                end
            end
        end
    end

    // completion window at the head, only over allocated entries
    always_comb begin
        robPkg::robIdxT idx;
        for (int i = 0; i < `COMMIT_W; i++) begin
            idx = robPkg::robIdxT'(head + robPkg::robIdxT'(i));
            rawReady[i] = done[idx] && (robPkg::robCountT'(i) < valid);
        end
    end

    // an entry may only retire behind older ready ones
    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int i = 0; i < `COMMIT_W; i++) begin
            chain = chain & rawReady[i];
            readyMask[i] = chain;
        end
    end

endmodule

/* hdl/robEntryRam.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module robEntryRam #(
    parameter int DEPTH    = `ROB_SIZE,
    parameter int RD_PORTS = `COMMIT_W,
    parameter int WR_PORTS = `DISPATCH_W
) (
    input  logic                              clk,
    input  logic [WR_PORTS-1:0]               wrEn,
    input  robPkg::robIdxT [WR_PORTS-1:0]     wrIdx,
    input  robPkg::robEntryT [WR_PORTS-1:0]   wrData,
    input  robPkg::robIdxT [RD_PORTS-1:0]     rdIdx,
    output robPkg::robEntryT [RD_PORTS-1:0]   rdData
);

    robPkg::robEntryT mem [DEPTH];

    // higher port wins on a shared address
    always_ff @(posedge clk) begin
        for (int w = 0; w < WR_PORTS; w++) begin
            if (wrEn[w]) begin
                mem[wrIdx[w]] <= wrData[w];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            rdData[r] = mem[rdIdx[r]]; // async read
        end
    end

endmodule

/* hdl/robPkg.sv */
`include "rob_defines.svh"

package robPkg;

    typedef logic [`ROB_IDX_W-1:0] robIdxT;

    // dir flips on every lap so two pointers can be aged
    typedef struct packed {
        logic   dir;
        robIdxT idx;
    } robPtrT;

    typedef logic [`ROB_IDX_W:0] robCountT; // 0..ROB_SIZE
    typedef logic [1:0]          slotCountT;

    typedef logic [`PREG_W-1:0] pregT;
    typedef logic [`AREG_W-1:0] aregT;
    typedef logic [`FTQ_W-1:0]  ftqTagT;

    typedef struct packed {
        logic   we;
        aregT   vrd;
        pregT   prd;
        ftqTagT ftqTag;
    } robEntryT;

    typedef struct packed {
        logic [`DISPATCH_W-1:0]     en; // contiguous from slot 0
        robEntryT [`DISPATCH_W-1:0] entry;
    } robDispatchT;

    typedef struct packed {
        logic   en;
        robPtrT ptr;
    } robWbPortT;

    typedef struct packed {
        robWbPortT [`WB_PORTS-1:0] port;
    } robWbT;

    typedef struct packed {
        logic   en;
        robPtrT ptr; // oldest wrong-path entry
    } robRedirectT;

    typedef struct packed {
        logic [`COMMIT_W-1:0]     en;
        slotCountT                num;
        slotCountT                weNum;
        robEntryT [`COMMIT_W-1:0] entry;
    } robCommitT;

    typedef struct packed {
        logic                     active;
        logic                     start;
        logic [`COMMIT_W-1:0]     en;
        slotCountT                num;
        slotCountT                weNum;
        robEntryT [`COMMIT_W-1:0] entry; // newest first
    } robWalkT;

    typedef enum logic {
        walkIdle,
        walkBusy
    } walkStateT;

endpackage

/* hdl/robWalkUnit.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module robWalkUnit (
    input  logic                               clk,
    input  logic                               rstN,
    input  robPkg::robRedirectT                redirect,
    input  robPkg::robPtrT                     tail,
    output robPkg::robIdxT [`COMMIT_W-1:0]     rdIdx,
    input  robPkg::robEntryT [`COMMIT_W-1:0]   rdData,
    output robPkg::robWalkT                    walk,
    output robPkg::robPtrT                     tailRewind,
    output logic                               rewindEn
);

    robPkg::walkStateT state;
    robPkg::robCountT  remain;    // left after the group on the bus
    robPkg::robIdxT    cursor;    // one above the next entry to walk
    robPkg::robPtrT    rewindPtr;

    robPkg::robCountT  squashCount;
    robPkg::robCountT  groupSrc;
    robPkg::slotCountT groupNum;
    logic [`COMMIT_W-1:0] groupMask;
    logic [`COMMIT_W-1:0] groupWe;
    robPkg::robIdxT    baseIdx;
    logic              advance;

    logic                             activeQ;
    logic                             startQ;
    logic [`COMMIT_W-1:0]             enQ;
    robPkg::slotCountT                numQ;
    robPkg::slotCountT                weNumQ;
    robPkg::robEntryT [`COMMIT_W-1:0] entryQ;

    // includes the redirected entry itself
    assign squashCount = robPkg::robCountT'(tail - redirect.ptr);

    assign groupSrc = (state == robPkg::walkIdle) ? squashCount : remain;
    assign baseIdx  = (state == robPkg::walkIdle) ? tail.idx : cursor;

    always_comb begin
        if (groupSrc > robPkg::robCountT'(`COMMIT_W)) begin
            groupNum = robPkg::slotCountT'(`COMMIT_W);
        end else begin
            groupNum = robPkg::slotCountT'(groupSrc);
        end
        for (int i = 0; i < `COMMIT_W; i++) begin
            groupMask[i] = (i < int'(groupNum));
            groupWe[i]   = groupMask[i] & rdData[i].we;
            rdIdx[i]     = robPkg::robIdxT'(baseIdx - robPkg::robIdxT'(i + 1)); // newest first
        end
    end

    assign advance = ((state == robPkg::walkIdle) && redirect.en) ||
                     ((state == robPkg::walkBusy) && (remain != '0));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= robPkg::walkIdle;
            remain  <= '0;
            activeQ <= 1'b0;
            startQ  <= 1'b0;
            enQ     <= '0;
            numQ    <= '0;
            weNumQ  <= '0;
        end else begin
            case (state)
                robPkg::walkIdle: begin
                    if (redirect.en) begin
                        state   <= robPkg::walkBusy;
                        activeQ <= 1'b1;
                        startQ  <= 1'b1;
                        enQ     <= groupMask;
                        numQ    <= groupNum;
                        weNumQ  <= robPkg::slotCountT'($countones(groupWe));
                        remain  <= robPkg::robCountT'(squashCount - groupNum);
                    end
                end
                robPkg::walkBusy: begin
                    startQ <= 1'b0;
                    if (remain == '0) begin
                        state   <= robPkg::walkIdle; // last group done
                        activeQ <= 1'b0;
                        enQ     <= '0;
                        numQ    <= '0;
                        weNumQ  <= '0;
                    end else begin
                        enQ    <= groupMask;
                        numQ   <= groupNum;
                        weNumQ <= robPkg::slotCountT'($countones(groupWe));
                        remain <= robPkg::robCountT'(remain - groupNum);
                    end
                end
                default: state <= robPkg::walkIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            entryQ <= rdData;
            cursor <= robPkg::robIdxT'(baseIdx - robPkg::robIdxT'(groupNum));
        end
        if ((state == robPkg::walkIdle) && redirect.en) begin
            rewindPtr <= redirect.ptr;
        end
    end

    always_comb begin
        walk.active = activeQ;
        walk.start  = startQ;
        walk.en     = enQ;
        walk.num    = numQ;
        walk.weNum  = weNumQ;
        walk.entry  = entryQ;
    end

    assign tailRewind = rewindPtr;
    assign rewindEn   = (state == robPkg::walkBusy) && (remain == '0);

endmodule

/* hdl/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry
`define ROB_SIZE    16
`define ROB_IDX_W   4

// slots per cycle
`define DISPATCH_W  2
`define COMMIT_W    2
`define WB_PORTS    2

// payload widths
`define PREG_W      6
`define AREG_W      5
`define FTQ_W       4

`endif

/* tb/reorderBufferTb.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module reorderBufferTb;

    localparam int CLK_PERIOD   = 8;
    localparam int RAND_CYCLES  = 300;
    localparam int CYCLE_BUDGET = 10 + 20 + 20 + 60 + 30 + RAND_CYCLES + 40;

    logic                clk;
    logic                rstN;
    robPkg::robDispatchT dispatch;
    robPkg::robPtrT      allocPtr;
    logic                full;
    robPkg::robWbT       wb;
    robPkg::robRedirectT redirect;
    robPkg::robCommitT   commit;
    robPkg::robWalkT     walk;

    robPkg::robEntryT payload [`ROB_SIZE];
    bit               doneBit [`ROB_SIZE];
    robPkg::robPtrT   liveQ [$];  // allocated entries oldest first
    robPkg::robPtrT   walkQ [$];  // expected walk order newest first
    robPkg::robPtrT   tailPtr;
    robPkg::robPtrT   rewindTarget;
    bit               walking;
    bit               walkFirst;
    int               expCommit;  // retire count due at the next sample
    int               allocCount;
    logic [31:0]      lfsr;

    reorderBuffer i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .dispatch(dispatch),
        .allocPtr(allocPtr),
        .full    (full),
        .wb      (wb),
        .redirect(redirect),
        .commit  (commit),
        .walk    (walk)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
                           input string name);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    // taps 32,22,2,1
    function automatic logic [31:0] nextRand(input int bits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < bits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic robPkg::robEntryT randEntry();
        logic [31:0] r;
        r = nextRand($bits(robPkg::robEntryT));
        return robPkg::robEntryT'(r[$bits(robPkg::robEntryT)-1:0]);
    endfunction

    task automatic clearInputs();
        dispatch = '0;
        wb       = '0;
        redirect = '0;
    endtask

    task automatic driveDispatch(input int n);
        for (int i = 0; i < `DISPATCH_W; i++) begin
            dispatch.en[i]    = (i < n);
            dispatch.entry[i] = randEntry();
        end
    endtask

    task automatic writeBack(input int port, input robPkg::robPtrT ptr);
        wb.port[port].en  = 1'b1;
        wb.port[port].ptr = ptr;
    endtask

    // picks pending entries in any age order
    task automatic driveWbPick(input bit randomCount);
        int cand [$];
        int k;
        for (int i = 0; i < liveQ.size(); i++) begin
            if (!doneBit[liveQ[i].idx]) begin
                cand.push_back(i);
            end
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (cand.size() != 0 && (!randomCount || nextRand(1) == 1)) begin
                k = int'(nextRand(8) % cand.size());
                writeBack(p, liveQ[cand[k]]);
                cand.delete(k);
            end
        end
    endtask

    task automatic startWalk(input robPkg::robPtrT target);
        robPkg::robPtrT p;
        bit             found;
        found = 1'b0;
        foreach (liveQ[i]) begin
            if (liveQ[i] == target) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("redirect names an entry that is not allocated");
            abortRun();
        end
        walkQ.delete();
        do begin
            p = liveQ.pop_back();
            walkQ.push_back(p);
        end while (p != target);
        walking      = 1'b1;
        walkFirst    = 1'b1;
        rewindTarget = target;
    endtask

    task automatic sampleOutputs();
        int             n;
        int             we;
        robPkg::robPtrT p;
        n  = expCommit;
        we = 0;
        checkEq(commit.en, (1 << n) - 1, "commit.en");
        checkEq(commit.num, n, "commit.num");
        for (int i = 0; i < n; i++) begin
            p = liveQ.pop_front();
            checkEq(commit.entry[i], payload[p.idx], "commit.entry");
            we += payload[p.idx].we;
        end
        checkEq(commit.weNum, we, "commit.weNum");
        if (walking && walkQ.size() != 0) begin
            n  = (walkQ.size() > `COMMIT_W) ? `COMMIT_W : walkQ.size();
            we = 0;
            checkEq(walk.active, 1, "walk.active");
            checkEq(walk.start, walkFirst, "walk.start");
            checkEq(walk.num, n, "walk.num");
            checkEq(walk.en, (1 << n) - 1, "walk.en");
            for (int i = 0; i < n; i++) begin
                p = walkQ.pop_front();
                checkEq(walk.entry[i], payload[p.idx], "walk.entry");
                we += payload[p.idx].we;
            end
            checkEq(walk.weNum, we, "walk.weNum");
            walkFirst = 1'b0;
        end else begin
            checkEq(walk.active, 0, "walk.active");
            checkEq(walk.start, 0, "walk.start");
            checkEq(walk.en, 0, "walk.en");
            if (walking) begin
                walking = 1'b0;
                tailPtr = rewindTarget; // tail rewound at this edge
            end
        end
        if (!walking) begin
            checkEq(allocPtr, tailPtr, "allocPtr");
        end
    endtask

    // drives one edge and checks what it produced
    task automatic stepCycle();
        int n;
        int freeSlots;
        bit accept;
        n         = $countones(dispatch.en);
        freeSlots = `ROB_SIZE - liveQ.size();
        expCommit = 0; // completion bits before this edge
        if (!walking && !redirect.en) begin
            while (expCommit < `COMMIT_W && expCommit < liveQ.size() &&
                   doneBit[liveQ[expCommit].idx]) begin
                expCommit++;
            end
        end
        #1;
        if (!walking && !redirect.en) begin
            checkEq(full, freeSlots < n, "full");
        end
        accept = (n != 0) && !walking && !redirect.en && (freeSlots >= n);
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb.port[p].en) begin
                doneBit[wb.port[p].ptr.idx] = 1'b1;
            end
        end
        if (redirect.en) begin
            startWalk(redirect.ptr);
        end
        if (accept) begin
            for (int i = 0; i < n; i++) begin
                payload[tailPtr.idx] = dispatch.entry[i];
                doneBit[tailPtr.idx] = 1'b0;
                liveQ.push_back(tailPtr);
                tailPtr = tailPtr + 1'b1;
                allocCount++;
            end
        end
        @(negedge clk);
        sampleOutputs();
        clearInputs();
    endtask

    task automatic drainAll(input int limit);
        int guard;
        guard = 0;
        while (liveQ.size() != 0) begin
            driveWbPick(1'b0);
            stepCycle();
            guard++;
            if (guard > limit) begin
                $display("entries still allocated after %0d drain cycles", limit);
                abortRun();
            end
        end
    endtask

    task automatic resetDut();
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic resetAndOrder();
        checkEq(full, 0, "full");
        checkEq(allocPtr, 0, "allocPtr");
        checkEq(commit.en, 0, "commit.en");
        checkEq(walk.active, 0, "walk.active");
        checkEq(walk.start, 0, "walk.start");
        checkEq(walk.en, 0, "walk.en");
        driveDispatch(2);
        stepCycle();
        writeBack(0, liveQ[1]); // younger first
        stepCycle();
        writeBack(0, liveQ[0]);
        stepCycle();
        drainAll(10);
    endtask

    task automatic retireWidth();
        driveDispatch(2);
        stepCycle();
        driveDispatch(2);
        stepCycle();
        writeBack(0, liveQ[2]);
        writeBack(1, liveQ[3]);
        stepCycle();
        writeBack(0, liveQ[0]);
        writeBack(1, liveQ[1]);
        stepCycle();
        drainAll(10);
    endtask

    task automatic backPressure();
        robPkg::robDispatchT held;
        int                  guard;
        for (int i = 0; i < `ROB_SIZE / 2; i++) begin
            driveDispatch(2);
            stepCycle();
        end
        driveDispatch(2);
        held = dispatch;
        repeat (5) begin
            dispatch = held; // blocked group is never allocated
            stepCycle();
        end
        writeBack(0, liveQ[0]);
        writeBack(1, liveQ[1]);
        stepCycle();
        guard = 0;
        while (liveQ.size() > `ROB_SIZE - 2) begin
            stepCycle();
            guard++;
            if (guard > 5) begin
                $display("no space freed after writing back the oldest entries");
                abortRun();
            end
        end
        driveDispatch(2);
        stepCycle();
        drainAll(20);
    endtask

    task automatic redirectWalk();
        int guard;
        for (int i = 0; i < 3; i++) begin
            driveDispatch(2);
            stepCycle();
        end
        driveDispatch(1);
        stepCycle();
        redirect.en  = 1'b1;
        redirect.ptr = liveQ[2]; // third oldest
        stepCycle();
        guard = 0;
        while (walking) begin
            stepCycle();
            guard++;
            if (guard > 10) begin
                $display("walk did not finish");
                abortRun();
            end
        end
        checkEq(allocPtr, rewindTarget, "allocPtr after walk");
        drainAll(10);
    endtask

    task automatic randomMix();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            driveDispatch(int'(nextRand(2) % 3));
            driveWbPick(1'b1);
            stepCycle();
        end
        drainAll(40);
        checkEq(allocCount > 3 * `ROB_SIZE, 1, "pointer laps");
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        lfsr         = 32'h8662;
        tailPtr      = '0;
        walking      = 1'b0;
        walkFirst    = 1'b0;
        expCommit    = 0;
        allocCount   = 0;
        clearInputs();
        resetDut();
        resetAndOrder();
        retireWidth();
        backPressure();
        redirectWalk();
        randomMix();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(2 * CYCLE_BUDGET * CLK_PERIOD);
        $display("timeout, tests did not finish within %0d cycles", 2 * CYCLE_BUDGET);
        abortRun();
    end

endmodule

/* tb/reorderBuffer_sva.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module reorderBuffer_sva (
    input logic                clk,
    input logic                rstN,
    input robPkg::robDispatchT dispatch,
    input robPkg::robPtrT      allocPtr,
    input logic                full,
    input robPkg::robCountT    validCount,
    input robPkg::robCommitT   commit,
    input robPkg::robWalkT     walk
);

    commitEnContig: assert property (@(posedge clk) disable iff (!rstN)
        (commit.en & (commit.en + 1'b1)) == '0)
        else $error("commit.en is not contiguous from slot 0");

    walkEnContig: assert property (@(posedge clk) disable iff (!rstN)
        (walk.en & (walk.en + 1'b1)) == '0)
        else $error("walk.en is not contiguous from slot 0");

    noCommitInWalk: assert property (@(posedge clk) disable iff (!rstN)
        walk.active |-> (commit.en == '0))
        else $error("commit seen while walking");

    countBound: assert property (@(posedge clk) disable iff (!rstN)
        validCount <= `ROB_SIZE)
        else $error("allocated count above buffer size");

    // rewind only moves the tail while walking
    allocHold: assert property (@(posedge clk) disable iff (!rstN)
        (full && (|dispatch.en) && !walk.active) |=> $stable(allocPtr))
        else $error("allocPtr moved while full");

endmodule

bind reorderBuffer reorderBuffer_sva i_sva (
    .clk       (clk),
    .rstN      (rstN),
    .dispatch  (dispatch),
    .allocPtr  (allocPtr),
    .full      (full),
    .validCount(validCount),
    .commit    (commit),
    .walk      (walk)
);

/* verilog.f */
+incdir+hdl
hdl/robPkg.sv
hdl/robEntryRam.sv
hdl/robCompletionTracker.sv
hdl/robWalkUnit.sv
hdl/reorderBuffer.sv
tb/reorderBuffer_sva.sv
tb/reorderBufferTb.sv
